/* Bender.yml */
package:
  name: enigma_ir

sources:
  - files:
      - logic/enigma_pkg.sv
      - logic/ir_pulse_timer.sv
      - logic/ir_frame_fsm.sv
      - logic/enigma_rotor_core.sv
      - logic/letter_buffer.sv
      - logic/enigma_ir_top.sv
  - target: test
    include_dirs:
      - verification
    files:
      - verification/enigma_ir_tb.sv

/* enigma_ir_top.f */
+incdir+verification
logic/enigma_pkg.sv
logic/ir_pulse_timer.sv
logic/ir_frame_fsm.sv
logic/enigma_rotor_core.sv
logic/letter_buffer.sv
logic/enigma_ir_top.sv
verification/enigma_ir_tb.sv

/* logic/enigma_ir_top.sv */
`timescale 1ns/1ps

module enigma_ir_top (
  input  logic                   clk_100_passthrough,
  input  logic                   rst_n,
  // demodulated ir, high is a mark
  input  logic                   ir_line,
  input  logic                   rotor_load,
  input  enigma_pkg::positions_t rotor_start,
  input  enigma_pkg::buf_addr_t  rd_addr,
  output logic                   cipher_valid,
  output enigma_pkg::letter_t    cipher_letter,
  output logic                   err_valid,
  output enigma_pkg::err_t       err_code,
  output enigma_pkg::count_t     letter_count,
  output enigma_pkg::letter_t    rd_data
);
  import enigma_pkg::*;

  // timer to fsm
  logic    pulse_edge;
  logic    pulse_level;
  width_t  pulse_width;
  width_t  idle_width;
  // fsm to cipher
  logic    letter_valid;
  letter_t letter;

  ir_pulse_timer u_timer (
    .clk_100_passthrough (clk_100_passthrough),
    .rst_n               (rst_n),
    .ir_line             (ir_line),
    .pulse_edge          (pulse_edge),
    .pulse_level         (pulse_level),
    .pulse_width         (pulse_width),
    .idle_width          (idle_width)
  );

  ir_frame_fsm u_frame (
    .clk_100_passthrough (clk_100_passthrough),
    .rst_n               (rst_n),
    .pulse_edge          (pulse_edge),
    .pulse_level         (pulse_level),
    .pulse_width         (pulse_width),
    .idle_width          (idle_width),
    .letter_valid        (letter_valid),
    .letter              (letter),
    .err_valid           (err_valid),
    .err_code            (err_code)
  );

  // two cycle step and encipher
  enigma_rotor_core u_core (
    .clk_100_passthrough (clk_100_passthrough),
    .rst_n               (rst_n),
    .rotor_load          (rotor_load),
    .rotor_start         (rotor_start),
    .letter_valid        (letter_valid),
    .letter              (letter),
    .cipher_valid        (cipher_valid),
    .cipher_letter       (cipher_letter)
  );

  letter_buffer u_buffer (
    .clk_100_passthrough (clk_100_passthrough),
    .rst_n               (rst_n),
    .cipher_valid        (cipher_valid),
    .cipher_letter       (cipher_letter),
    .rd_addr             (rd_addr),
    .rd_data             (rd_data),
    .letter_count        (letter_count)
  );

endmodule

/* logic/enigma_pkg.sv */
package enigma_pkg;

  // letter code 0..25 maps to A..Z
  typedef logic [4:0]  letter_t;
  // fast rotor in [4:0], middle in [9:5], slow in [14:10]
  typedef logic [14:0] positions_t;
  typedef logic [9:0]  buf_addr_t;
  typedef logic [10:0] count_t;
  // pulse width in clock cycles saturating at all ones
  typedef logic [11:0] width_t;
  typedef logic [1:0]  err_t;

  // receiver frame states
  typedef enum logic [2:0] {
    idle,
    start_mark,
    start_space,
    bit_mark,
    bit_space,
    stop_mark
  } frame_state_t;

  // one ir timing unit is 20 cycles
  localparam int     unit_cycles    = 20;
  localparam width_t start_mark_min = width_t'(6 * unit_cycles);
  localparam width_t space_one_min  = width_t'(2 * unit_cycles);
  localparam width_t space_max      = width_t'(5 * unit_cycles);
  localparam width_t timeout_cycles = width_t'(16 * unit_cycles);

  localparam int letter_bits   = 5;
  localparam int alphabet_size = 26;
  localparam int buf_depth     = 1024;

  localparam err_t err_none    = 2'd0;
  localparam err_t err_timing  = 2'd1;
  localparam err_t err_timeout = 2'd2;
  localparam err_t err_range   = 2'd3;

  // entry 0 is rotor I, 1 is rotor II, 2 is rotor III
  localparam letter_t rotor_fwd [3][26] = '{
    '{4, 10, 12, 5, 11, 6, 3, 16, 21, 25, 13, 19, 14,
      22, 24, 7, 23, 20, 18, 15, 0, 8, 1, 17, 2, 9},
    '{0, 9, 3, 10, 18, 8, 17, 20, 23, 1, 11, 7, 22,
      19, 12, 2, 16, 6, 25, 13, 15, 24, 5, 21, 14, 4},
    '{1, 3, 5, 7, 9, 11, 2, 15, 17, 19, 23, 21, 25,
      13, 24, 4, 8, 22, 6, 0, 10, 12, 20, 18, 16, 14}
  };

  // return path uses the inverse of each forward wiring
  localparam letter_t rotor_inv [3][26] = '{
    '{20, 22, 24, 6, 0, 3, 5, 15, 21, 25, 1, 4, 2,
      10, 12, 19, 7, 23, 18, 11, 17, 8, 13, 16, 14, 9},
    '{0, 9, 15, 2, 25, 22, 17, 11, 5, 1, 3, 10, 14,
      19, 24, 20, 16, 6, 4, 13, 7, 23, 12, 8, 21, 18},
    '{19, 0, 6, 1, 15, 2, 18, 3, 16, 4, 20, 5, 21,
      13, 25, 7, 24, 8, 23, 9, 22, 11, 17, 10, 14, 12}
  };

  // reflector B pairs letters so the cipher is its own inverse
  localparam letter_t reflector_b [26] = '{
    24, 17, 20, 7, 16, 18, 11, 3, 15, 23, 13, 6, 14,
    10, 12, 8, 4, 1, 5, 25, 2, 22, 21, 9, 0, 19
  };

  // turnover letters Q E V
  localparam letter_t notch [3] = '{16, 4, 21};

endpackage

/* logic/enigma_rotor_core.sv */
`timescale 1ns/1ps

module enigma_rotor_core (
  input  logic                   clk_100_passthrough,
  input  logic                   rst_n,
  input  logic                   rotor_load,
  input  enigma_pkg::positions_t rotor_start,
  input  logic                   letter_valid,
  input  enigma_pkg::letter_t    letter,
  output logic                   cipher_valid,
  output enigma_pkg::letter_t    cipher_letter
);
  import enigma_pkg::*;

  // pos[0] fast, pos[1] middle, pos[2] slow
  // fast rotor is wired as rotor III so table entry is 2 - r
  letter_t pos [3];
  letter_t pos_step [3];
  letter_t pos_load [3];
  logic    s1_valid;
  letter_t s1_letter;
  letter_t path;

  // a + b mod 26 with both below 26
  function automatic letter_t add26(input letter_t a, input letter_t b);
    logic [5:0] s;
    s = {1'b0, a} + {1'b0, b};
    if (s >= 6'(alphabet_size)) begin
      s = s - 6'(alphabet_size);
    end
    return s[4:0];
  endfunction

  // a - b mod 26
  function automatic letter_t sub26(input letter_t a, input letter_t b);
    logic [5:0] d;
    if (a >= b) begin
      d = {1'b0, a} - {1'b0, b};
    end else begin
      d = {1'b0, a} + 6'(alphabet_size) - {1'b0, b};
    end
    return d[4:0];
  endfunction

  // one rotor contact offset by the rotor position on both sides
  function automatic letter_t rotor_pass(input letter_t x, input letter_t p,
                                         input int idx, input logic inverse);
    letter_t off;
    letter_t ent;
    off = add26(x, p);
    ent = inverse ? rotor_inv[idx][off] : rotor_fwd[idx][off];
    return sub26(ent, p);
  endfunction

  // odometer stepping carries only through a rotor that moves
  always_comb begin
    pos_step    = pos;
    pos_step[0] = add26(pos[0], 5'd1);
    if (pos[0] == notch[2]) begin
      pos_step[1] = add26(pos[1], 5'd1);
      if (pos[1] == notch[1]) begin
        pos_step[2] = add26(pos[2], 5'd1);
      end
    end
  end

  // out of range start position loads as A
  always_comb begin
    for (int r = 0; r < 3; r++) begin
      if (rotor_start[5*r +: 5] > letter_t'(alphabet_size - 1)) begin
        pos_load[r] = '0;
      end else begin
        pos_load[r] = rotor_start[5*r +: 5];
      end
    end
  end

  // stage 2 uses positions already stepped for s1_letter
  always_comb begin
    path = s1_letter;
    for (int r = 0; r < 3; r++) begin
      path = rotor_pass(path, pos[r], 2 - r, 1'b0);
    end
    path = reflector_b[path];
    for (int r = 2; r >= 0; r--) begin
      path = rotor_pass(path, pos[r], 2 - r, 1'b1);
    end
  end

  always_ff @(posedge clk_100_passthrough or negedge rst_n) begin
    if (!rst_n) begin
      pos          <= '{default: '0};
      s1_valid     <= 1'b0;
      cipher_valid <= 1'b0;
    end else begin
      cipher_valid <= s1_valid;
      // load beats a letter in the same cycle
      if (rotor_load) begin
        pos      <= pos_load;
        s1_valid <= 1'b0;
      end else if (letter_valid) begin
        pos      <= pos_step;
        s1_valid <= 1'b1;
      end else begin
        s1_valid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_100_passthrough) begin
    if (letter_valid) begin
      s1_letter <= letter;
    end
    if (s1_valid) begin
      cipher_letter <= path;
    end
  end

endmodule

/* logic/ir_frame_fsm.sv */
`timescale 1ns/1ps

module ir_frame_fsm (
  input  logic                clk_100_passthrough,
  input  logic                rst_n,
  input  logic                pulse_edge,
  input  logic                pulse_level,
  input  enigma_pkg::width_t  pulse_width,
  input  enigma_pkg::width_t  idle_width,
  output logic                letter_valid,
  output enigma_pkg::letter_t letter,
  output logic                err_valid,
  output enigma_pkg::err_t    err_code
);
  import enigma_pkg::*;

  frame_state_t state;
  frame_state_t state_d;
  logic [2:0]   bit_cnt;
  logic [2:0]   bit_cnt_d;
  letter_t      shreg;
  letter_t      shreg_d;
  letter_t      code_d;
  logic         space_bit;
  // cleared by an error, set again once a long quiet gap is seen
  logic         in_sync;
  logic         in_sync_d;
  logic         fire_letter;
  logic         fire_err;
  err_t         err_d;

  always_comb begin
    state_d     = state;
    bit_cnt_d   = bit_cnt;
    shreg_d     = shreg;
    in_sync_d   = in_sync;
    fire_letter = 1'b0;
    fire_err    = 1'b0;
    err_d       = err_none;
    // long space is a one, short space a zero
    space_bit   = (pulse_width >= space_one_min);
    code_d      = {shreg[3:0], space_bit};
    if (state != idle && !pulse_edge && idle_width >= timeout_cycles) begin
      // line went quiet mid frame
      fire_err = 1'b1;
      err_d    = err_timeout;
    end else if (pulse_edge) begin
      unique case (state)
        idle: begin
          // rising edge after a gap longer than any in-frame space
          if (!pulse_level && (in_sync || pulse_width > space_max)) begin
            state_d   = start_mark;
            in_sync_d = 1'b1;
          end
        end
        start_mark: begin
          if (pulse_width >= start_mark_min) begin
            state_d = start_space;
          end else begin
            fire_err = 1'b1;
            err_d    = err_timing;
          end
        end
        start_space: begin
          if (pulse_width >= space_one_min && pulse_width <= space_max) begin
            state_d   = bit_mark;
            bit_cnt_d = '0;
          end else begin
            fire_err = 1'b1;
            err_d    = err_timing;
          end
        end
        bit_mark: begin
          // bit marks are one unit
          if (pulse_width < space_one_min) begin
            state_d = bit_space;
          end else begin
            fire_err = 1'b1;
            err_d    = err_timing;
          end
        end
        bit_space: begin
          if (pulse_width > space_max) begin
            fire_err = 1'b1;
            err_d    = err_timing;
          end else begin
            shreg_d = code_d;
            if (bit_cnt == 3'(letter_bits - 1)) begin
              // this rising edge opens the closing mark
              if (code_d > letter_t'(alphabet_size - 1)) begin
                fire_err = 1'b1;
                err_d    = err_range;
              end else begin
                fire_letter = 1'b1;
                state_d     = stop_mark;
              end
            end else begin
              bit_cnt_d = bit_cnt + 3'd1;
              state_d   = bit_mark;
            end
          end
        end
        stop_mark: begin
          if (pulse_width < space_one_min) begin
            state_d = idle;
          end else begin
            fire_err = 1'b1;
            err_d    = err_timing;
          end
        end
        default: state_d = idle;
      endcase
    end
    if (fire_err) begin
      state_d   = idle;
      in_sync_d = 1'b0;
    end
  end

  always_ff @(posedge clk_100_passthrough or negedge rst_n) begin
    if (!rst_n) begin
      state        <= idle;
      bit_cnt      <= '0;
      in_sync      <= 1'b1;
      letter_valid <= 1'b0;
      err_valid    <= 1'b0;
      err_code     <= err_none;
    end else begin
      state        <= state_d;
      bit_cnt      <= bit_cnt_d;
      in_sync      <= in_sync_d;
      letter_valid <= fire_letter;
      err_valid    <= fire_err;
      err_code     <= err_d;
    end
  end

  // shift register and letter payload
  always_ff @(posedge clk_100_passthrough) begin
    shreg <= shreg_d;
    if (fire_letter) begin
      letter <= code_d;
    end
  end

endmodule

/* logic/ir_pulse_timer.sv */
`timescale 1ns/1ps

module ir_pulse_timer (
  input  logic               clk_100_passthrough,
  input  logic               rst_n,
  input  logic               ir_line,
  output logic               pulse_edge,
  output logic               pulse_level,
  output enigma_pkg::width_t pulse_width,
  output enigma_pkg::width_t idle_width
);
  import enigma_pkg::*;

  // two flop synchronizer, then one more flop for edge detect
  logic   sync_1;
  logic   sync_2;
  logic   line_d;
  width_t cnt;

  always_ff @(posedge clk_100_passthrough or negedge rst_n) begin
    if (!rst_n) begin
      // line idles low
      sync_1      <= 1'b0;
      sync_2      <= 1'b0;
      line_d      <= 1'b0;
      cnt         <= '0;
      pulse_edge  <= 1'b0;
      pulse_level <= 1'b0;
      pulse_width <= '0;
    end else begin
      sync_1     <= ir_line;
      sync_2     <= sync_1;
      line_d     <= sync_2;
      pulse_edge <= sync_2 ^ line_d;
      if (sync_2 != line_d) begin
        // level that just ended and how long it lasted
        pulse_level <= line_d;
        pulse_width <= cnt;
        cnt         <= width_t'(1);
      end else if (cnt != '1) begin
        // saturate on long idle
        cnt <= cnt + width_t'(1);
      end
    end
  end

  // running count since last edge
  assign idle_width = cnt;

endmodule

/* logic/letter_buffer.sv */
`timescale 1ns/1ps

module letter_buffer (
  input  logic                  clk_100_passthrough,
  input  logic                  rst_n,
  input  logic                  cipher_valid,
  input  enigma_pkg::letter_t   cipher_letter,
  input  enigma_pkg::buf_addr_t rd_addr,
  output enigma_pkg::letter_t   rd_data,
  output enigma_pkg::count_t    letter_count
);
  import enigma_pkg::*;

  letter_t   mem [buf_depth];
  buf_addr_t wr_addr;

  // write slot is the count mod depth
  assign wr_addr = letter_count[$bits(buf_addr_t)-1:0];

  // simple dual port ram
  // write on cipher strobe and read one cycle later
  always_ff @(posedge clk_100_passthrough) begin
    if (cipher_valid) begin
      mem[wr_addr] <= cipher_letter;
    end
    rd_data <= mem[rd_addr];
  end

  // letter count wraps at buffer depth
  always_ff @(posedge clk_100_passthrough or negedge rst_n) begin
    if (!rst_n) begin
      letter_count <= '0;
    end else if (cipher_valid) begin
      if (letter_count == count_t'(buf_depth - 1)) begin
        letter_count <= '0;
      end else begin
        letter_count <= letter_count + count_t'(1);
      end
    end
  end

endmodule

/* verification/enigma_ir_tb_model.svh */
// reference model of the three rotor machine
// fast to slow the wheels are rotor III, II, I, then reflector B

// model positions with [0] fast, [1] middle, [2] slow
int model_pos [3];

// 32 bit xorshift with shifts 13 17 5
function automatic int unsigned xorshift32(input int unsigned s);
  int unsigned x;
  x = s;
  x = x ^ (x << 13);
  x = x ^ (x >> 17);
  x = x ^ (x << 5);
  return x;
endfunction

// start positions from a packed load word
function automatic void model_load(input positions_t p);
  int f;
  for (int r = 0; r < 3; r++) begin
    f = (p >> (5 * r)) & 31;
    // out of range field reads as A
    model_pos[r] = (f < alphabet_size) ? f : 0;
  end
endfunction

// one pass through a wheel where wheel 0 is rotor I
function automatic int wheel_pass(input int x, input int p, input int wheel, input bit back);
  int k;
  int e;
  k = (x + p) % alphabet_size;
  if (back) begin
    e = rotor_inv[wheel][k];
  end else begin
    e = rotor_fwd[wheel][k];
  end
  return (e - p + alphabet_size) % alphabet_size;
endfunction

// odometer step carries only out of a wheel that sat on its notch
function automatic void model_step();
  bit mid_carry;
  bit slow_carry;
  mid_carry    = (model_pos[0] == notch[2]);
  slow_carry   = mid_carry && (model_pos[1] == notch[1]);
  model_pos[0] = (model_pos[0] + 1) % alphabet_size;
  if (mid_carry) begin
    model_pos[1] = (model_pos[1] + 1) % alphabet_size;
  end
  if (slow_carry) begin
    model_pos[2] = (model_pos[2] + 1) % alphabet_size;
  end
endfunction

// step first then encipher with the new positions
function automatic int model_encipher(input int plain);
  int x;
  model_step();
  x = plain;
  // fast position r uses wheel 2 - r
  for (int r = 0; r < 3; r++) begin
    x = wheel_pass(x, model_pos[r], 2 - r, 1'b0);
  end
  x = reflector_b[x];
  for (int r = 2; r >= 0; r--) begin
    x = wheel_pass(x, model_pos[r], 2 - r, 1'b1);
  end
  return x;
endfunction

/* verification/enigma_ir_tb.sv */
`timescale 1ns/1ps

module enigma_ir_tb;
  import enigma_pkg::*;

  // table entry kinds
  localparam int k_load     = 0;
  localparam int k_letter   = 1;
  localparam int k_replay   = 2;
  localparam int k_collide  = 3;
  localparam int k_bad      = 4;
  localparam int k_readback = 5;
  // bad frame flavours
  localparam int bad_range  = 0;
  localparam int bad_cut    = 1;
  localparam int bad_short  = 2;
  // data or expected value left to the model
  localparam int from_model = -1;
  localparam int max_entries = 64;
  // sync and edge detect 3, fsm 1, core 2
  localparam int cipher_latency = 6;
  // low gap before a frame is longer than any space inside one
  localparam int gap_cycles = int'(space_max) + unit_cycles;

  logic       clk_100_passthrough;
  logic       rst_n;
  logic       ir_line;
  logic       rotor_load;
  positions_t rotor_start;
  buf_addr_t  rd_addr;
  logic       cipher_valid;
  letter_t    cipher_letter;
  logic       err_valid;
  err_t       err_code;
  count_t     letter_count;
  letter_t    rd_data;

  int tbl_kind [max_entries];
  int tbl_data [max_entries];
  int tbl_want [max_entries];
  int n_entries;

  int unsigned rng_state;
  int cycle;
  int cycle_limit;
  int rise_cyc;
  int test_no;
  int test_errs;
  int pass_cnt;
  int fail_cnt;
  positions_t last_load;
  // strobes seen since the last clear
  int cipher_q [$];
  int cipher_cyc_q [$];
  int err_q [$];
  // plaintext and expected ciphertext of each good letter in send order
  int plain_hist [$];
  int exp_hist [$];

  `include "enigma_ir_tb_model.svh"

  enigma_ir_top DUT (
    .clk_100_passthrough (clk_100_passthrough),
    .rst_n               (rst_n),
    .ir_line             (ir_line),
    .rotor_load          (rotor_load),
    .rotor_start         (rotor_start),
    .rd_addr             (rd_addr),
    .cipher_valid        (cipher_valid),
    .cipher_letter       (cipher_letter),
    .err_valid           (err_valid),
    .err_code            (err_code),
    .letter_count        (letter_count),
    .rd_data             (rd_data)
  );

  initial begin
    clk_100_passthrough = 1'b0;
    forever #50 clk_100_passthrough = ~clk_100_passthrough;
  end

  // run limit armed once the table is built
  initial begin
    int wd;
    wd = 0;
    wait (cycle_limit > 0);
    while (wd < cycle_limit) begin
      @(posedge clk_100_passthrough);
      wd++;
    end
    $display("run did not finish within %0d cycles", cycle_limit);
    $display("Simulation FAILED");
    $finish;
  end

  function automatic int next_rand(input int modulus);
    rng_state = xorshift32(rng_state);
    return int'(rng_state % $unsigned(modulus));
  endfunction

  function automatic int pack_pos(input int slow, input int mid, input int fast);
    return slow * 1024 + mid * 32 + fast;
  endfunction

  function automatic void add_entry(input int kind, input int data, input int want);
    tbl_kind[n_entries] = kind;
    tbl_data[n_entries] = data;
    tbl_want[n_entries] = want;
    n_entries++;
  endfunction

  // worst case cycles of one entry where an all ones letter frame is 39 units
  function automatic int entry_budget(input int kind, input int data);
    int units;
    units = 39;
    if (kind == k_bad && data == bad_cut) begin
      units = units + 20;
    end
    if (kind == k_load) begin
      units = 1;
    end
    if (kind == k_readback) begin
      return buf_depth + 10;
    end
    return units * unit_cycles + 10;
  endfunction

  function automatic string kind_name(input int kind);
    case (kind)
      k_load:    return "load";
      k_letter:  return "letter";
      k_replay:  return "replay";
      k_collide: return "collide";
      k_bad:     return "bad";
      default:   return "readback";
    endcase
  endfunction

  task automatic build_table();
    n_entries = 0;
    // AAA then five A with known answer BDZGO
    add_entry(k_load, 0, from_model);
    add_entry(k_letter, 0, 1);
    add_entry(k_letter, 0, 3);
    add_entry(k_letter, 0, 25);
    add_entry(k_letter, 0, 6);
    add_entry(k_letter, 0, 14);
    // fast two before V and middle on E so the third letter carries into slow
    add_entry(k_load, pack_pos(7, 4, 19), from_model);
    repeat (4) add_entry(k_letter, from_model, from_model);
    add_entry(k_load, from_model, from_model);
    repeat (3) add_entry(k_letter, from_model, from_model);
    // fast one before V gives a single carry on the second letter
    add_entry(k_load, pack_pos(2, 10, 20), from_model);
    repeat (3) add_entry(k_letter, from_model, from_model);
    // same start again with good letters 12..14 sent back as ciphertext
    add_entry(k_load, pack_pos(2, 10, 20), from_model);
    add_entry(k_replay, 12, from_model);
    add_entry(k_replay, 13, from_model);
    add_entry(k_replay, 14, from_model);
    add_entry(k_collide, 3, from_model);
    add_entry(k_letter, from_model, from_model);
    add_entry(k_bad, bad_range, int'(err_range));
    add_entry(k_letter, from_model, from_model);
    add_entry(k_bad, bad_cut, int'(err_timeout));
    add_entry(k_letter, from_model, from_model);
    add_entry(k_bad, bad_short, int'(err_timing));
    add_entry(k_letter, from_model, from_model);
    add_entry(k_readback, 0, from_model);
  endtask

  task automatic report_error(input string msg);
    $display("%s", msg);
    test_errs++;
  endtask

  task automatic finish_test(input string name);
    $display("test %0d %s: %s", test_no, name, (test_errs == 0) ? "ok" : "bad");
    if (test_errs == 0) begin
      pass_cnt++;
    end else begin
      fail_cnt++;
    end
    test_no++;
  endtask

  // one clock with outputs sampled on the falling edge
  task automatic tick();
    @(negedge clk_100_passthrough);
    cycle++;
    if (cipher_valid) begin
      cipher_q.push_back(int'(cipher_letter));
      cipher_cyc_q.push_back(cycle);
    end
    if (err_valid) begin
      err_q.push_back(int'(err_code));
    end
  endtask

  task automatic clear_seen();
    cipher_q.delete();
    cipher_cyc_q.delete();
    err_q.delete();
  endtask

  task automatic hold_line(input logic level, input int cycles);
    ir_line = level;
    repeat (cycles) tick();
  endtask

  task automatic wait_strobe(input bit for_err, input int limit);
    int n;
    n = 0;
    while (n < limit && (for_err ? err_q.size() : cipher_q.size()) == 0) begin
      tick();
      n++;
    end
  endtask

  task automatic load_rotors(input positions_t p);
    rotor_start = p;
    rotor_load  = 1'b1;
    tick();
    rotor_load  = 1'b0;
    tick();
    model_load(p);
  endtask

  // gap, start mark, start space, bits msb first, closing mark
  task automatic send_frame(input int start_units, input int code, input int nbits,
                            input bit closing, input bit load_mid);
    hold_line(1'b0, gap_cycles);
    hold_line(1'b1, start_units * unit_cycles);
    if (nbits > 0) begin
      hold_line(1'b0, 4 * unit_cycles);
    end
    for (int i = 0; i < nbits; i++) begin
      hold_line(1'b1, unit_cycles);
      hold_line(1'b0, ((code >> (4 - i)) & 1) ? 3 * unit_cycles : unit_cycles);
    end
    if (closing) begin
      ir_line  = 1'b1;
      rise_cyc = cycle;
      for (int i = 0; i < unit_cycles; i++) begin
        // letter_valid is sampled by the core at the fifth rising edge
        rotor_load = load_mid && (i == 4);
        tick();
      end
    end
    ir_line = 1'b0;
  endtask

  task automatic check_cipher(input int want);
    assert (cipher_q.size() == 1) else
      report_error($sformatf("expected one cipher_valid strobe, saw %0d", cipher_q.size()));
    assert (err_q.size() == 0) else
      report_error("err_valid strobe on a good frame");
    if (cipher_q.size() > 0) begin
      assert (cipher_q[0] == want) else
        report_error($sformatf("CHECK FAILED cipher_letter exp %0h got %0h",
                               want, cipher_q[0]));
      assert (cipher_cyc_q[0] - rise_cyc == cipher_latency) else
        report_error($sformatf("CHECK FAILED cipher_valid latency exp %0h got %0h",
                               cipher_latency, cipher_cyc_q[0] - rise_cyc));
    end
  endtask

  initial begin
    int kind;
    int data;
    int want;
    int plain;
    int model_out;
    int total;
    ir_line     = 1'b0;
    rotor_load  = 1'b0;
    rotor_start = '0;
    rd_addr     = '0;
    rst_n       = 1'b0;
    rng_state   = 32'h8530_81f8;
    build_table();
    total = 0;
    for (int t = 0; t < n_entries; t++) begin
      total += entry_budget(tbl_kind[t], tbl_data[t]);
    end
    cycle_limit = 2 * total + 1000;

    repeat (8) tick();
    rst_n = 1'b1;
    repeat (2) tick();
    test_errs = 0;
    assert (cipher_valid === 1'b0 && err_valid === 1'b0) else
      report_error("a strobe is high after reset");
    assert (letter_count === '0) else
      report_error($sformatf("CHECK FAILED letter_count exp 0 got %0h", letter_count));
    finish_test("reset");

    for (int t = 0; t < n_entries; t++) begin
      kind      = tbl_kind[t];
      data      = tbl_data[t];
      want      = tbl_want[t];
      test_errs = 0;
      clear_seen();
      case (kind)
        k_load: begin
          if (data == from_model) begin
            data = pack_pos(next_rand(alphabet_size), next_rand(alphabet_size),
                            next_rand(alphabet_size));
          end
          last_load = positions_t'(data);
          load_rotors(last_load);
        end
        k_letter, k_replay: begin
          if (kind == k_replay) begin
            // self inverse so ciphertext back in gives plaintext out
            plain = exp_hist[data];
            want  = plain_hist[data];
          end else begin
            plain = (data == from_model) ? next_rand(alphabet_size) : data;
          end
          model_out = model_encipher(plain);
          if (want == from_model) begin
            want = model_out;
          end
          send_frame(8, plain, letter_bits, 1'b1, 1'b0);
          wait_strobe(1'b0, 10);
          check_cipher(want);
          plain_hist.push_back(plain);
          exp_hist.push_back(want);
        end
        k_collide: begin
          // reload lands on the letter_valid cycle
          rotor_start = last_load;
          model_load(last_load);
          send_frame(8, data, letter_bits, 1'b1, 1'b1);
          wait_strobe(1'b0, 10);
          assert (cipher_q.size() == 0) else
            report_error("letter sent together with a rotor load was not dropped");
        end
        k_bad: begin
          case (data)
            bad_range: send_frame(8, 29, letter_bits, 1'b1, 1'b0);
            bad_cut:   send_frame(8, next_rand(alphabet_size), 3, 1'b0, 1'b0);
            default:   send_frame(3, 0, 0, 1'b0, 1'b0);
          endcase
          wait_strobe(1'b1, int'(timeout_cycles) + 4 * unit_cycles);
          assert (err_q.size() == 1) else
            report_error($sformatf("expected one err_valid strobe, saw %0d", err_q.size()));
          if (err_q.size() > 0) begin
            assert (err_q[0] == want) else
              report_error($sformatf("CHECK FAILED err_code exp %0h got %0h", want, err_q[0]));
          end
          assert (cipher_q.size() == 0) else
            report_error("cipher_valid strobe on a rejected frame");
        end
        default: begin
          assert (letter_count == exp_hist.size()) else
            report_error($sformatf("CHECK FAILED letter_count exp %0h got %0h",
                                   exp_hist.size(), letter_count));
          // registered read returns data on the next edge
          for (int a = 0; a < exp_hist.size(); a++) begin
            rd_addr = buf_addr_t'(a);
            tick();
            assert (rd_data == exp_hist[a]) else
              report_error($sformatf("CHECK FAILED rd_data at %0h exp %0h got %0h",
                                     a, exp_hist[a], rd_data));
          end
        end
      endcase
      finish_test(kind_name(kind));
    end

    $display("tests passed %0d, failed %0d", pass_cnt, fail_cnt);
    if (fail_cnt == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule
